// File: files.f
logic/cache_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/cache_fsm.sv
logic/line_transfer.sv
logic/cache_subsystem.sv
tests/cache_fsm_properties.sv
tests/cache_checker.sv
tests/tb_cache_subsystem.sv

// File: run.sh
#!/bin/sh
# Build the cache subsystem testbench with Verilator, run it, scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cache_subsystem -f files.f -o sim_cache

./obj_dir/sim_cache +verilator+error+limit+100 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"

// File: tests/tb_cache_subsystem.sv
/*
 * Testbench for cache_subsystem: directed tests, then a seeded random mix.
 * Fetches and data accesses use separate address regions, since the
 * two caches are not coherent. Memory acks each word after 1 to 4 cycles.
 */
`timescale 1ns/1ps

module tb_cache_subsystem;

    import cache_pkg::*;

    localparam int                SETS         = 16;
    localparam int                NUM_RANDOM   = 150;
    localparam int                PLANNED_REQS = 2 * NUM_RANDOM + 16;
    localparam logic [ADDR_W-1:0] I_BASE       = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] D_BASE       = 32'h0000_2000;
    // Same index, next tag.
    localparam logic [ADDR_W-1:0] D_STRIDE     = SETS * LINE_WORDS * 4;

    logic              clk = 1'b0;
    logic              arst = 1'b1;
    fetch_req_t        fetch_req = '0;
    data_req_t         data_req = '0;
    logic              mispred = 1'b0;
    logic [WORD_W-1:0] mem_rdata = '0;
    logic              mem_ack = 1'b0;
    logic [WORD_W-1:0] instr;
    logic [WORD_W-1:0] rdata;
    logic              stall_i;
    logic              stall_d;
    mem_req_t          mem_req;
    int                chk_checks;
    int                chk_errors;

    logic [WORD_W-1:0] mem_q [logic [ADDR_W-1:0]];
    int                mem_wait = 0;
    int                local_errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                errs_before = 0;

    always #50 clk = ~clk;

    cache_subsystem #(
        .SETS (SETS)
    ) UUT (
        .i_clk            (clk),
        .i_arst           (arst),
        .i_fetch          (fetch_req),
        .i_data           (data_req),
        .i_branch_mispred (mispred),
        .i_mem_rdata      (mem_rdata),
        .i_mem_ack        (mem_ack),
        .o_instr          (instr),
        .o_rdata          (rdata),
        .o_stall_i        (stall_i),
        .o_stall_d        (stall_d),
        .o_mem            (mem_req)
    );

    cache_checker u_checker (
        .i_clk            (clk),
        .i_arst           (arst),
        .i_fetch          (fetch_req),
        .i_data           (data_req),
        .i_branch_mispred (mispred),
        .i_stall_i        (stall_i),
        .i_stall_d        (stall_d),
        .i_instr          (instr),
        .i_rdata          (rdata),
        .o_checks         (chk_checks),
        .o_errors         (chk_errors)
    );

    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        if (mem_q.exists(addr)) begin
            return mem_q[addr];
        end
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    // ------------------------------------------------------------------
    // Memory model, one word per ack
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (!mem_ack && mem_req.valid) begin
            if (mem_wait == 0) begin
                mem_wait = $urandom_range(4, 1);
            end
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_ack <= 1'b1;
                if (mem_req.we) begin
                    mem_q[mem_req.addr] = mem_req.wdata;
                end else begin
                    mem_rdata <= mem_word(mem_req.addr);
                end
            end
        end
    end

    function automatic int total_errors();
        return chk_errors + local_errors + UUT.u_cache_fsm.u_fsm_props.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
                               input logic [WORD_W-1:0] actual);
        if (actual !== expected) begin
            local_errors++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        local_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Holds the fetch until an edge with the stall low.
    task automatic do_fetch(input logic [ADDR_W-1:0] addr, output int stalls);
        stalls = 0;
        fetch_req <= '{valid: 1'b1, addr: addr};
        @(posedge clk);
        while (stall_i) begin
            stalls++;
            @(posedge clk);
        end
        fetch_req.valid <= 1'b0;
    endtask

    task automatic do_data(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [WORD_W-1:0] wdata, output int stalls);
        stalls = 0;
        data_req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
        @(posedge clk);
        while (stall_d) begin
            stalls++;
            @(posedge clk);
        end
        data_req.valid <= 1'b0;
    endtask

    task automatic random_fetches();
        int                stalls;
        logic [ADDR_W-1:0] addr;
        repeat (NUM_RANDOM) begin
            addr = I_BASE + ($urandom_range(127, 0) << 2);
            do_fetch(addr, stalls);
        end
    endtask

    task automatic random_data();
        int                stalls;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        repeat (NUM_RANDOM) begin
            we    = ($urandom_range(9, 0) < 4);
            addr  = D_BASE + ($urandom_range(255, 0) << 2);
            wdata = $urandom;
            do_data(we, addr, wdata, stalls);
        end
    endtask

    // One edge later the checker counts include the last completion.
    task automatic finish_test(input string name);
        int errs;
        @(posedge clk);
        errs = total_errors() - errs_before;
        errs_before = total_errors();
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %-26s %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "passed" : "failed", errs);
    endtask

    initial begin
        #(PLANNED_REQS * 40 * 100);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        int                stalls;
        int                checks_before;
        logic [WORD_W-1:0] stored;
        void'($urandom(32'h944c));
        repeat (3) @(posedge clk);
        arst <= 1'b0;

        repeat (8) begin
            @(posedge clk);
            check_value("o_stall_i", 32'd0, WORD_W'(stall_i));
            check_value("o_stall_d", 32'd0, WORD_W'(stall_d));
            check_value("o_mem.valid", 32'd0, WORD_W'(mem_req.valid));
        end
        finish_test("idle after reset");

        do_fetch(I_BASE, stalls);
        if (stalls == 0) begin
            report_problem("fetch miss did not raise o_stall_i");
        end
        do_fetch(I_BASE + 32'h4, stalls);
        check_value("o_stall_i cycles", 32'd0, stalls);
        // A hit must not start a line transfer.
        check_value("o_mem.valid", 32'd0, WORD_W'(mem_req.valid));
        repeat (2) begin
            @(posedge clk);
            check_value("o_mem.valid", 32'd0, WORD_W'(mem_req.valid));
        end
        finish_test("fetch miss then hit");

        do_data(1'b0, D_BASE + 32'h10, '0, stalls);
        if (stalls == 0) begin
            report_problem("load miss did not raise o_stall_d");
        end
        stored = $urandom;
        do_data(1'b1, D_BASE + 32'h14, stored, stalls);
        do_data(1'b0, D_BASE + 32'h14, '0, stalls);
        finish_test("load miss, store, load");

        // Conflicting load pushes the dirty line out.
        do_data(1'b0, D_BASE + 32'h14 + D_STRIDE, '0, stalls);
        check_value("memory word", stored, mem_word(D_BASE + 32'h14));
        do_data(1'b0, D_BASE + 32'h14, '0, stalls);
        finish_test("dirty eviction");

        mispred <= 1'b1;
        fetch_req <= '{valid: 1'b1, addr: I_BASE + 32'h100};
        repeat (12) begin
            @(posedge clk);
            check_value("o_mem.valid", 32'd0, WORD_W'(mem_req.valid));
        end
        mispred <= 1'b0;
        @(posedge clk);
        while (stall_i) begin
            @(posedge clk);
        end
        fetch_req.valid <= 1'b0;
        finish_test("mispredict holds off refill");

        checks_before = chk_checks;
        fork
            random_fetches();
            random_data();
        join
        if (chk_checks == checks_before) begin
            report_problem("checker saw no completed requests");
        end
        finish_test("random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, chk_checks, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tests/cache_checker.sv
/*
 * Watches the cache ports and compares returned words with a reference
 * image: the initial memory pattern plus every completed store.
 * Fetches are not compared while a mispredict is high.
 * Assumes fetched addresses are never stored to.
 */
`timescale 1ns/1ps

module cache_checker (
    input  logic                         i_clk,
    input  logic                         i_arst,
    input  cache_pkg::fetch_req_t        i_fetch,
    input  cache_pkg::data_req_t         i_data,
    input  logic                         i_branch_mispred,
    input  logic                         i_stall_i,
    input  logic                         i_stall_d,
    input  logic [cache_pkg::WORD_W-1:0] i_instr,
    input  logic [cache_pkg::WORD_W-1:0] i_rdata,
    output int                           o_checks,
    output int                           o_errors
);

    import cache_pkg::*;

    logic [WORD_W-1:0] ref_q [logic [ADDR_W-1:0]];
    int                check_cnt = 0;
    int                err_cnt = 0;

    // Initial memory contents, mixed from every address bit.
    function automatic logic [WORD_W-1:0] fill_pattern(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        if (ref_q.exists(addr)) begin
            return ref_q[addr];
        end
        return fill_pattern(addr);
    endfunction

    task automatic compare(input string name, input logic [ADDR_W-1:0] addr,
                           input logic [WORD_W-1:0] actual);
        logic [WORD_W-1:0] expected;
        expected = ref_word(addr);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAIL time=%0t signal=%s addr=%h expected=%h actual=%h",
                     $time, name, addr, expected, actual);
        end
    endtask

    // A valid request with its stall low completes at this edge.
    always @(posedge i_clk) begin
        if (!i_arst) begin
            if (i_fetch.valid && !i_stall_i && !i_branch_mispred) begin
                compare("o_instr", {i_fetch.addr[ADDR_W-1:2], 2'b00}, i_instr);
            end
            if (i_data.valid && !i_stall_d) begin
                if (i_data.we) begin
                    ref_q[{i_data.addr[ADDR_W-1:2], 2'b00}] = i_data.wdata;
                end else begin
                    compare("o_rdata", {i_data.addr[ADDR_W-1:2], 2'b00}, i_rdata);
                end
            end
        end
        o_checks <= check_cnt;
        o_errors <= err_cnt;
    end

endmodule

// File: tests/cache_fsm_properties.sv
/*
 * Concurrent checks on the miss state machine strobes.
 * Bound into every cache_fsm instance; all checks are off during reset.
 * fail_count lets the testbench see assertion failures.
 */
`timescale 1ns/1ps

module cache_fsm_properties (
    input logic i_clk,
    input logic i_arst,
    input logic i_xfer_done,
    input logic i_instr_we,
    input logic i_dcache_we,
    input logic i_write_start,
    input logic i_read_start_i,
    input logic i_read_start_d
);

    int fail_count = 0;

    // One line transfer requested at a time.
    a_one_start: assert property (@(posedge i_clk) disable iff (i_arst)
        $onehot0({i_write_start, i_read_start_i, i_read_start_d}))
    else begin
        $error("more than one line transfer start is high");
        fail_count++;
    end

    a_one_fill: assert property (@(posedge i_clk) disable iff (i_arst)
        !(i_instr_we && i_dcache_we))
    else begin
        $error("instruction and data fill strobes are high together");
        fail_count++;
    end

    // Fills only land in the done cycle.
    a_fill_on_done: assert property (@(posedge i_clk) disable iff (i_arst)
        (i_instr_we || i_dcache_we) |-> i_xfer_done)
    else begin
        $error("fill strobe without transfer done");
        fail_count++;
    end

endmodule

bind cache_fsm cache_fsm_properties u_fsm_props (
    .i_clk          (i_clk),
    .i_arst         (i_arst),
    .i_xfer_done    (i_xfer_done),
    .i_instr_we     (o_instr_we),
    .i_dcache_we    (o_dcache_we),
    .i_write_start  (o_write_start),
    .i_read_start_i (o_read_start_i),
    .i_read_start_d (o_read_start_d)
);

// File: logic/cache_subsystem.sv
/*
 * Miss-handling path: icache and dcache lookup, miss state machine,
 * and the line-transfer engine on a word-wide memory port.
 * SETS (power of two, 2..256) sizes both caches.
 */
`timescale 1ns/1ps

module cache_subsystem #(
    parameter int SETS = 16
) (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  cache_pkg::fetch_req_t         i_fetch,
    input  cache_pkg::data_req_t          i_data,
    input  logic                          i_branch_mispred,
    input  logic [cache_pkg::WORD_W-1:0]  i_mem_rdata,
    input  logic                          i_mem_ack,
    output logic [cache_pkg::WORD_W-1:0]  o_instr,
    output logic [cache_pkg::WORD_W-1:0]  o_rdata,
    output logic                          o_stall_i,
    output logic                          o_stall_d,
    output cache_pkg::mem_req_t           o_mem
);

    import cache_pkg::*;

    logic              icache_hit;
    logic              dcache_hit;
    logic              dcache_dirty;
    logic              xfer_done;
    logic              instr_we;
    logic              dcache_we;
    logic              write_start;
    logic              read_start_i;
    logic              read_start_d;
    line_t             fill_line;
    line_t             victim_line;
    logic [ADDR_W-1:0] victim_addr;

    // ------------------------------------------------------------------
    // Lookup stage
    // ------------------------------------------------------------------
    icache #(
        .SETS (SETS)
    ) u_icache (
        .i_clk       (i_clk),
        .i_arst      (i_arst),
        .i_fetch     (i_fetch),
        .i_fill_we   (instr_we),
        .i_fill_line (fill_line),
        .o_hit       (icache_hit),
        .o_instr     (o_instr)
    );

    dcache #(
        .SETS (SETS)
    ) u_dcache (
        .i_clk          (i_clk),
        .i_arst         (i_arst),
        .i_data         (i_data),
        .i_fill_we      (dcache_we),
        .i_fill_line    (fill_line),
        .o_hit          (dcache_hit),
        .o_victim_dirty (dcache_dirty),
        .o_victim_line  (victim_line),
        .o_victim_addr  (victim_addr),
        .o_rdata        (o_rdata)
    );

    // ------------------------------------------------------------------
    // Control stage
    // ------------------------------------------------------------------
    cache_fsm u_cache_fsm (
        .i_clk            (i_clk),
        .i_arst           (i_arst),
        .i_icache_hit     (icache_hit),
        .i_dcache_hit     (dcache_hit),
        .i_dcache_dirty   (dcache_dirty),
        .i_xfer_done      (xfer_done),
        .i_mem_access     (i_data.valid),
        .i_branch_mispred (i_branch_mispred),
        .o_stall_i        (o_stall_i),
        .o_stall_d        (o_stall_d),
        .o_instr_we       (instr_we),
        .o_dcache_we      (dcache_we),
        .o_write_start    (write_start),
        .o_read_start_i   (read_start_i),
        .o_read_start_d   (read_start_d)
    );

    // ------------------------------------------------------------------
    // Memory stage
    // ------------------------------------------------------------------
    line_transfer u_line_transfer (
        .i_clk          (i_clk),
        .i_arst         (i_arst),
        .i_read_start_i (read_start_i),
        .i_read_start_d (read_start_d),
        .i_write_start  (write_start),
        .i_fetch_addr   (i_fetch.addr),
        .i_data_addr    (i_data.addr),
        .i_victim_addr  (victim_addr),
        .i_victim_line  (victim_line),
        .i_mem_rdata    (i_mem_rdata),
        .i_mem_ack      (i_mem_ack),
        .o_mem          (o_mem),
        .o_fill_line    (fill_line),
        .o_done         (xfer_done)
    );

endmodule

// File: logic/line_transfer.sv
/*
 * Moves one cache line over a word-wide request/ack memory port.
 * A start is accepted only while idle; words go in ascending order and
 * each request is held until i_mem_ack. o_done pulses one cycle after
 * the last ack. Write-back takes the victim line captured at the start.
 */
`timescale 1ns/1ps

module line_transfer (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  logic                          i_read_start_i,
    input  logic                          i_read_start_d,
    input  logic                          i_write_start,
    input  logic [cache_pkg::ADDR_W-1:0]  i_fetch_addr,
    input  logic [cache_pkg::ADDR_W-1:0]  i_data_addr,
    input  logic [cache_pkg::ADDR_W-1:0]  i_victim_addr,
    input  cache_pkg::line_t              i_victim_line,
    input  logic [cache_pkg::WORD_W-1:0]  i_mem_rdata,
    input  logic                          i_mem_ack,
    output cache_pkg::mem_req_t           o_mem,
    output cache_pkg::line_t              o_fill_line,
    output logic                          o_done
);

    import cache_pkg::*;

    localparam int LADDR_W = ADDR_W - OFFSET_W;

    logic               busy_q;
    logic               done_q;
    xfer_op_t           op_q;
    logic [WSEL_W-1:0]  cnt_q;
    logic [LADDR_W-1:0] laddr_q;
    line_t              buf_q;

    logic               accept;
    logic               last;
    xfer_op_t           start_op;
    logic [ADDR_W-1:0]  start_addr;

    assign accept = ~busy_q & ~done_q & (i_write_start | i_read_start_d | i_read_start_i);
    assign last   = (cnt_q == WSEL_W'(LINE_WORDS - 1));

    // Address for whichever start is raised.
    always_comb begin
        start_op   = XFER_READ;
        start_addr = i_fetch_addr;
        if (i_write_start) begin
            start_op   = XFER_WRITE;
            start_addr = i_victim_addr;
        end else if (i_read_start_d) begin
            start_addr = i_data_addr;
        end
    end

    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            op_q   <= XFER_READ;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy_q <= 1'b1;
                op_q   <= start_op;
                cnt_q  <= '0;
            end else if (busy_q && i_mem_ack) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Line address and line buffer.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            laddr_q <= start_addr[ADDR_W-1:OFFSET_W];
            if (start_op == XFER_WRITE) begin
                buf_q <= i_victim_line;
            end
        end else if (busy_q && i_mem_ack && op_q == XFER_READ) begin
            buf_q[cnt_q] <= i_mem_rdata;
        end
    end

    always_comb begin
        o_mem.valid = busy_q;
        o_mem.we    = busy_q & (op_q == XFER_WRITE);
        o_mem.addr  = {laddr_q, cnt_q, {BYTE_W{1'b0}}};
        o_mem.wdata = buf_q[cnt_q];
    end

    assign o_fill_line = buf_q;
    assign o_done      = done_q;

endmodule

// File: logic/cache_fsm.sv
/*
 * Miss state machine for the instruction and data caches.
 * Only one miss is in flight; a data miss wins over an instruction miss.
 * Starts are levels held until i_xfer_done; fill strobes are the done
 * pulse gated by state. A mispredict in IDLE holds off instruction misses.
 */
`timescale 1ns/1ps

module cache_fsm (
    input  logic i_clk,
    input  logic i_arst,
    input  logic i_icache_hit,
    input  logic i_dcache_hit,
    input  logic i_dcache_dirty,
    input  logic i_xfer_done,
    input  logic i_mem_access,
    input  logic i_branch_mispred,

    output logic o_stall_i,
    output logic o_stall_d,
    output logic o_instr_we,
    output logic o_dcache_we,
    output logic o_write_start,
    output logic o_read_start_i,
    output logic o_read_start_d
);

    import cache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;

    logic i_miss;
    logic d_miss;

    // Miss conditions seen by the lookup stage.
    assign i_miss = ~i_icache_hit & ~i_branch_mispred;
    assign d_miss = ~i_dcache_hit & i_mem_access;

    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (d_miss) begin
                    state_d = i_dcache_dirty ? WRITE_BACK : ALLOCATE_D;
                end else if (i_miss) begin
                    state_d = ALLOCATE_I;
                end
            end
            ALLOCATE_I: begin
                if (i_xfer_done) begin
                    state_d = IDLE;
                end
            end
            ALLOCATE_D: begin
                if (i_xfer_done) begin
                    state_d = IDLE;
                end
            end
            // Victim is out, now fetch the new line.
            WRITE_BACK: begin
                if (i_xfer_done) begin
                    state_d = ALLOCATE_D;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    always_comb begin
        o_stall_i      = i_miss;
        o_stall_d      = d_miss;
        o_instr_we     = 1'b0;
        o_dcache_we    = 1'b0;
        o_write_start  = 1'b0;
        o_read_start_i = 1'b0;
        o_read_start_d = 1'b0;
        case (state_q)
            IDLE: begin
                o_write_start  = d_miss & i_dcache_dirty;
                o_read_start_d = d_miss & ~i_dcache_dirty;
                // Data side goes first.
                o_read_start_i = i_miss & ~d_miss;
            end
            ALLOCATE_I: begin
                o_stall_i      = 1'b1;
                o_instr_we     = i_xfer_done;
                o_read_start_i = ~i_xfer_done;
            end
            ALLOCATE_D: begin
                o_stall_d      = 1'b1;
                o_dcache_we    = i_xfer_done;
                o_read_start_d = ~i_xfer_done;
            end
            WRITE_BACK: begin
                o_stall_d     = 1'b1;
                o_write_start = ~i_xfer_done;
            end
            default: begin
                o_stall_i = 1'b0;
                o_stall_d = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/dcache.sv
/*
 * Direct-mapped write-back data cache, SETS lines, power of two (2..256).
 * Lookup and victim outputs are combinational from the request.
 * Store hits write one word and set dirty; a fill writes the line clean.
 * An invalid request reports a hit.
 */
`timescale 1ns/1ps

module dcache #(
    parameter int SETS = 16
) (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  cache_pkg::data_req_t          i_data,
    input  logic                          i_fill_we,
    input  cache_pkg::line_t              i_fill_line,
    output logic                          o_hit,
    output logic                          o_victim_dirty,
    output cache_pkg::line_t              o_victim_line,
    output logic [cache_pkg::ADDR_W-1:0]  o_victim_addr,
    output logic [cache_pkg::WORD_W-1:0]  o_rdata
);

    import cache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;
    logic [TAG_W-1:0] tag_q  [SETS];
    line_t            line_q [SETS];

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WSEL_W-1:0] wsel;
    logic              tag_hit;
    logic              store_hit;

    assign idx  = i_data.addr[OFFSET_W +: IDX_W];
    assign tag  = i_data.addr[ADDR_W-1 -: TAG_W];
    assign wsel = i_data.addr[BYTE_W +: WSEL_W];

    assign tag_hit   = valid_q[idx] & (tag_q[idx] == tag);
    assign store_hit = i_data.valid & i_data.we & tag_hit & ~i_fill_we;

    assign o_hit   = ~i_data.valid | tag_hit;
    assign o_rdata = line_q[idx][wsel];

    // ------------------------------------------------------------------
    // Victim line at the request index
    // ------------------------------------------------------------------
    assign o_victim_dirty = valid_q[idx] & dirty_q[idx];
    assign o_victim_line  = line_q[idx];
    assign o_victim_addr  = {tag_q[idx], idx, {OFFSET_W{1'b0}}};

    // Valid and dirty bits.
    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fill_we) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end else if (store_hit) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // Tag and data arrays.
    always_ff @(posedge i_clk) begin
        if (i_fill_we) begin
            tag_q[idx]  <= tag;
            line_q[idx] <= i_fill_line;
        end else if (store_hit) begin
            line_q[idx][wsel] <= i_data.wdata;
        end
    end

endmodule

// File: logic/icache.sv
/*
 * Direct-mapped instruction cache, SETS lines, power of two (2..256).
 * Lookup is combinational. An invalid fetch reports a hit.
 * The refill line is written at the current fetch index.
 */
`timescale 1ns/1ps

module icache #(
    parameter int SETS = 16
) (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  cache_pkg::fetch_req_t         i_fetch,
    input  logic                          i_fill_we,
    input  cache_pkg::line_t              i_fill_line,
    output logic                          o_hit,
    output logic [cache_pkg::WORD_W-1:0]  o_instr
);

    import cache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_q  [SETS];
    line_t            line_q [SETS];

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WSEL_W-1:0] wsel;

    // Address split.
    assign idx  = i_fetch.addr[OFFSET_W +: IDX_W];
    assign tag  = i_fetch.addr[ADDR_W-1 -: TAG_W];
    assign wsel = i_fetch.addr[BYTE_W +: WSEL_W];

    assign o_hit   = ~i_fetch.valid | (valid_q[idx] & (tag_q[idx] == tag));
    assign o_instr = line_q[idx][wsel];

    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            valid_q <= '0;
        end else if (i_fill_we) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // Tag and data arrays.
    always_ff @(posedge i_clk) begin
        if (i_fill_we) begin
            tag_q[idx]  <= tag;
            line_q[idx] <= i_fill_line;
        end
    end

endmodule

// File: logic/cache_pkg.sv
/*
 * Shared types for the miss-handling path of the cache subsystem.
 * Lines are LINE_WORDS words of WORD_W bits; the byte offset within
 * a line is fixed at OFFSET_W bits. Stores are whole words only.
 */
package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;

    // Byte offset inside a word, word select, and full line offset.
    localparam int BYTE_W   = 2;
    localparam int WSEL_W   = $clog2(LINE_WORDS);
    localparam int OFFSET_W = BYTE_W + WSEL_W;

    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } data_req_t;

    // One word request on the memory port, word aligned.
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        ALLOCATE_I = 2'b01,
        ALLOCATE_D = 2'b10,
        WRITE_BACK = 2'b11
    } miss_state_t;

    typedef enum logic {
        XFER_READ  = 1'b0,
        XFER_WRITE = 1'b1
    } xfer_op_t;

endpackage
